// File: flit_queue.sv
`include "noc_settings.svh"

module flit_queue (
    input  logic                  clk,
    input  logic                  arst_n,
    input  noc_flit_pkg::flit_t   in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output noc_flit_pkg::flit_t   out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    import noc_flit_pkg::*;

    localparam int DEPTH = `NOC_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // storage
    flit_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    // full queue still takes a flit when the head leaves this edge
    assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // payload write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: input_lane.sv
`include "noc_settings.svh"

module input_lane #(
    parameter noc_flit_pkg::coord_t cur_x = `NOC_CUR_X,
    parameter noc_flit_pkg::coord_t cur_y = `NOC_CUR_Y
) (
    input  logic                      clk,
    input  logic                      arst_n,
    // link from the neighbour
    input  noc_flit_pkg::flit_t       in_data,
    input  logic                      in_valid,
    output logic                      in_ready,
    // request towards the switch
    output noc_flit_pkg::flit_t       req_flit,
    output logic                      req_valid,
    output noc_route_pkg::port_sel_t  req_port,
    input  logic                      grant
);

    import noc_flit_pkg::*;
    import noc_route_pkg::*;

    flit_t  head_flit;
    coord_t head_x;
    coord_t head_y;

    ////////////////////////////////////////
    // input queue
    ////////////////////////////////////////

    // grant always lands on a valid head, so it pops directly
    flit_queue u_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (head_flit),
        .out_valid (req_valid),
        .out_ready (grant)
    );

    assign req_flit = head_flit;
    assign head_x   = head_flit.dst_x;
    assign head_y   = head_flit.dst_y;

    ////////////////////////////////////////
    // route computation
    ////////////////////////////////////////

    // dimension order
    // x first, then y, then eject here
    always_comb begin
        if (head_x != cur_x) begin
            req_port = port_xpos;
        end else if (head_y != cur_y) begin
            req_port = port_ypos;
        end else begin
            req_port = port_eject;
        end
    end

endmodule

// File: mesh_router.f
+incdir+.
noc_flit_pkg.sv
noc_route_pkg.sv
flit_queue.sv
input_lane.sv
output_switch.sv
mesh_router.sv
tb_mesh_router.sv

// File: mesh_router.sv
`include "noc_settings.svh"

module mesh_router #(
    parameter noc_flit_pkg::coord_t cur_x = `NOC_CUR_X,
    parameter noc_flit_pkg::coord_t cur_y = `NOC_CUR_Y
) (
    input  logic                 clk,
    input  logic                 arst_n,
    // input links
    input  noc_flit_pkg::flit_t  in_xpos,
    input  noc_flit_pkg::flit_t  in_ypos,
    input  logic                 in_xpos_valid,
    input  logic                 in_ypos_valid,
    output logic                 in_xpos_ready,
    output logic                 in_ypos_ready,
    // output links and local eject
    output noc_flit_pkg::flit_t  out_xpos,
    output noc_flit_pkg::flit_t  out_ypos,
    output noc_flit_pkg::flit_t  eject,
    output logic                 out_xpos_valid,
    output logic                 out_ypos_valid,
    output logic                 eject_valid,
    input  logic                 out_xpos_ready,
    input  logic                 out_ypos_ready,
    input  logic                 eject_ready
);

    import noc_flit_pkg::*;
    import noc_route_pkg::*;

    // lane to switch
    flit_t      xpos_req_flit;
    flit_t      ypos_req_flit;
    logic       xpos_req_valid;
    logic       ypos_req_valid;
    port_sel_t  xpos_req_port;
    port_sel_t  ypos_req_port;
    logic       xpos_grant;
    logic       ypos_grant;

    ////////////////////////////////////////
    // input lanes
    ////////////////////////////////////////

    input_lane #(.cur_x(cur_x), .cur_y(cur_y)) lane_xpos (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (in_xpos),
        .in_valid  (in_xpos_valid),
        .in_ready  (in_xpos_ready),
        .req_flit  (xpos_req_flit),
        .req_valid (xpos_req_valid),
        .req_port  (xpos_req_port),
        .grant     (xpos_grant)
    );

    input_lane #(.cur_x(cur_x), .cur_y(cur_y)) lane_ypos (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (in_ypos),
        .in_valid  (in_ypos_valid),
        .in_ready  (in_ypos_ready),
        .req_flit  (ypos_req_flit),
        .req_valid (ypos_req_valid),
        .req_port  (ypos_req_port),
        .grant     (ypos_grant)
    );

    ////////////////////////////////////////
    // switch
    ////////////////////////////////////////

    // lane 0 is x-positive, lane 1 is y-positive
    output_switch u_switch (
        .clk         (clk),
        .arst_n      (arst_n),
        .lane0_flit  (xpos_req_flit),
        .lane1_flit  (ypos_req_flit),
        .lane0_valid (xpos_req_valid),
        .lane1_valid (ypos_req_valid),
        .lane0_port  (xpos_req_port),
        .lane1_port  (ypos_req_port),
        .lane0_grant (xpos_grant),
        .lane1_grant (ypos_grant),
        .xpos_data   (out_xpos),
        .ypos_data   (out_ypos),
        .eject_data  (eject),
        .xpos_valid  (out_xpos_valid),
        .ypos_valid  (out_ypos_valid),
        .eject_valid (eject_valid),
        .xpos_ready  (out_xpos_ready),
        .ypos_ready  (out_ypos_ready),
        .eject_ready (eject_ready)
    );

endmodule

// File: mesh_router_vectors.txt
# test lane dst_x dst_y payload gap exp_port back_pressure
# lanes 0 and 1 are in_xpos and in_ypos
# ports 0 1 2 are out_xpos out_ypos eject
1 0 3 5 a0000001 0 0 0
1 1 0 1 b0000002 2 0 0
1 0 2 1 a0000003 1 1 0
1 1 2 7 b0000004 0 1 0
2 0 2 5 a0000011 0 2 0
2 1 2 5 b0000012 3 2 0
3 0 6 0 a0000021 0 0 0
3 0 6 1 a0000022 0 0 0
3 0 5 2 a0000023 0 0 0
3 1 1 5 b0000024 0 0 0
3 1 7 5 b0000025 0 0 0
3 1 0 3 b0000026 0 0 0
4 0 2 0 a0000031 0 1 1
4 0 2 1 a0000032 0 1 1
4 0 2 2 a0000033 0 1 1
4 0 2 3 a0000034 0 1 1
4 0 2 4 a0000035 0 1 1
4 1 2 3 b0000036 0 1 1
4 1 2 6 b0000037 0 1 1
4 1 2 7 b0000038 0 1 1
4 1 2 0 b0000039 0 1 1
4 1 2 1 b000003a 0 1 1
5 0 4 4 a0000041 0 0 0
5 1 2 5 b0000042 0 2 0
5 0 7 0 a0000043 0 0 0
5 1 2 5 b0000044 0 2 0

// File: noc_flit_pkg.sv
`include "noc_settings.svh"

package noc_flit_pkg;

    ////////////////////////////////////////
    // flit format
    ////////////////////////////////////////

    // widths pulled from the settings header
    localparam int COORD_W   = `NOC_COORD_W;
    localparam int PAYLOAD_W = `NOC_PAYLOAD_W;

    // one mesh coordinate
    typedef logic [COORD_W-1:0] coord_t;

    // flit as it travels on every link
    // destination first, then payload
    // no source, tag or opcode fields, the node never looks at them
    // msb side
    //   dst_x   : column of the target node
    //   dst_y   : row of the target node
    // lsb side
    //   payload : opaque user data, passed through untouched
    typedef struct packed {
        coord_t                 dst_x;
        coord_t                 dst_y;
        logic [PAYLOAD_W-1:0]   payload;
    } flit_t;

    // 3 + 3 + 32 = 38 bits with the default settings
    // valid is not part of the flit, it rides beside it on each link

endpackage

// File: noc_route_pkg.sv
package noc_route_pkg;

    ////////////////////////////////////////
    // routing decisions
    ////////////////////////////////////////

    // output port picked for a head flit
    // encoding doubles as the output index inside the switch
    typedef enum logic [1:0] {
        port_xpos  = 2'd0,
        port_ypos  = 2'd1,
        port_eject = 2'd2
    } port_sel_t;

    ////////////////////////////////////////
    // switch dimensions
    ////////////////////////////////////////

    // out_xpos, out_ypos, eject
    localparam int NUM_OUT = 3;

    // in_xpos, in_ypos
    localparam int NUM_LANES = 2;

endpackage

// File: noc_settings.svh
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

////////////////////////////////////////
// flit field widths
////////////////////////////////////////

// data carried by one flit
`define NOC_PAYLOAD_W 32

// one mesh coordinate, enough for an 8x8 mesh
`define NOC_COORD_W 3

////////////////////////////////////////
// buffering and placement
////////////////////////////////////////

// entries in each input queue
`define NOC_QUEUE_DEPTH 4

// default node position in the mesh
// overridden per node through the cur_x / cur_y parameters
`define NOC_CUR_X 2
`define NOC_CUR_Y 5

`endif

// File: output_switch.sv
module output_switch (
    input  logic                      clk,
    input  logic                      arst_n,
    // lane requests
    input  noc_flit_pkg::flit_t       lane0_flit,
    input  noc_flit_pkg::flit_t       lane1_flit,
    input  logic                      lane0_valid,
    input  logic                      lane1_valid,
    input  noc_route_pkg::port_sel_t  lane0_port,
    input  noc_route_pkg::port_sel_t  lane1_port,
    output logic                      lane0_grant,
    output logic                      lane1_grant,
    // registered outputs
    output noc_flit_pkg::flit_t       xpos_data,
    output noc_flit_pkg::flit_t       ypos_data,
    output noc_flit_pkg::flit_t       eject_data,
    output logic                      xpos_valid,
    output logic                      ypos_valid,
    output logic                      eject_valid,
    input  logic                      xpos_ready,
    input  logic                      ypos_ready,
    input  logic                      eject_ready
);

    import noc_flit_pkg::*;
    import noc_route_pkg::*;

    // lanes gathered into arrays
    flit_t                  lane_flit [NUM_LANES];
    logic [NUM_LANES-1:0]   lane_valid;
    port_sel_t              lane_port [NUM_LANES];

    // per output, indexed by port_sel_t encoding
    logic [NUM_LANES-1:0]   req [NUM_OUT];
    logic [NUM_LANES-1:0]   gnt [NUM_OUT];
    flit_t                  stage_data [NUM_OUT];
    logic [NUM_OUT-1:0]     stage_valid;
    logic [NUM_OUT-1:0]     stage_ready;
    logic [NUM_OUT-1:0]     can_load;
    // lane that won the last contended round
    logic [NUM_OUT-1:0]     last_win;

    assign lane_flit[0] = lane0_flit;
    assign lane_flit[1] = lane1_flit;
    assign lane_valid   = {lane1_valid, lane0_valid};
    assign lane_port[0] = lane0_port;
    assign lane_port[1] = lane1_port;

    assign stage_ready[port_xpos]  = xpos_ready;
    assign stage_ready[port_ypos]  = ypos_ready;
    assign stage_ready[port_eject] = eject_ready;

    ////////////////////////////////////////
    // allocation and output stages
    ////////////////////////////////////////

    for (genvar o = 0; o < NUM_OUT; o++) begin : g_out
        // requests aimed at this output
        for (genvar l = 0; l < NUM_LANES; l++) begin : g_req
            assign req[o][l] = lane_valid[l] && (lane_port[l] == port_sel_t'(o));
        end

        // empty stage, or its flit leaves this edge
        assign can_load[o] = !stage_valid[o] || stage_ready[o];

        // round robin, the other lane wins on contention
        assign gnt[o][0] = can_load[o] && req[o][0] && (!req[o][1] || last_win[o]);
        assign gnt[o][1] = can_load[o] && req[o][1] && (!req[o][0] || !last_win[o]);

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                stage_valid[o] <= 1'b0;
                last_win[o]    <= 1'b0;
            end else begin
                if (can_load[o]) begin
                    stage_valid[o] <= |gnt[o];
                end
                // only contended grants move the pointer
                if (can_load[o] && (&req[o])) begin
                    last_win[o] <= ~last_win[o];
                end
            end
        end

        // payload register
        always_ff @(posedge clk) begin
            if (|gnt[o]) begin
                stage_data[o] <= gnt[o][1] ? lane_flit[1] : lane_flit[0];
            end
        end
    end

    // a lane asks for one output only, so at most one term is set
    assign lane0_grant = gnt[port_xpos][0] | gnt[port_ypos][0] | gnt[port_eject][0];
    assign lane1_grant = gnt[port_xpos][1] | gnt[port_ypos][1] | gnt[port_eject][1];

    assign xpos_data   = stage_data[port_xpos];
    assign ypos_data   = stage_data[port_ypos];
    assign eject_data  = stage_data[port_eject];
    assign xpos_valid  = stage_valid[port_xpos];
    assign ypos_valid  = stage_valid[port_ypos];
    assign eject_valid = stage_valid[port_eject];

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the mesh router testbench with verilator
LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_mesh_router -f mesh_router.f -o tb_mesh_router
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mesh_router > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log
if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "no verdict found in $LOG"
    exit 1
fi
exit 0

// File: tb_mesh_router.sv
`include "noc_settings.svh"

module tb_mesh_router;

    timeunit 1ns;
    timeprecision 100ps;

    import noc_flit_pkg::*;
    import noc_route_pkg::*;

    localparam int MAX_VEC = 64;

    logic       clk;
    logic       arst_n;
    // lane 0 is in_xpos, lane 1 is in_ypos
    flit_t      in_data [2];
    logic [1:0] in_valid;
    logic [1:0] in_ready;
    // index follows port_sel_t encoding
    flit_t      o_data [3];
    logic [2:0] o_valid;
    logic [2:0] o_ready;

    // vectors as read from the file
    int    v_test [MAX_VEC];
    int    v_lane [MAX_VEC];
    int    v_gap  [MAX_VEC];
    int    v_port [MAX_VEC];
    int    v_bp   [MAX_VEC];
    flit_t v_flit [MAX_VEC];
    int    n_vec;

    // expected flits per lane and port at lane*3 + port
    flit_t      exp_q [6][$];
    int         errors;
    int         cycles;
    int         limit;
    int         test_start;
    int         stall_cnt;
    int         n_ok;
    int         n_bad;
    logic       bp_mode;
    logic [2:0] held;
    flit_t      held_data [3];

    mesh_router #(.cur_x(3'd2), .cur_y(3'd5)) uut (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_xpos        (in_data[0]),
        .in_ypos        (in_data[1]),
        .in_xpos_valid  (in_valid[0]),
        .in_ypos_valid  (in_valid[1]),
        .in_xpos_ready  (in_ready[0]),
        .in_ypos_ready  (in_ready[1]),
        .out_xpos       (o_data[0]),
        .out_ypos       (o_data[1]),
        .eject          (o_data[2]),
        .out_xpos_valid (o_valid[0]),
        .out_ypos_valid (o_valid[1]),
        .eject_valid    (o_valid[2]),
        .out_xpos_ready (o_ready[0]),
        .out_ypos_ready (o_ready[1]),
        .eject_ready    (o_ready[2])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // compare helpers
    ////////////////////////////////////////

    function automatic string port_label(input int p);
        case (p)
            0:       return "out_xpos";
            1:       return "out_ypos";
            default: return "eject";
        endcase
    endfunction

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            $display("Fail %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_port(input string name, input port_sel_t got, input port_sel_t exp);
        if (got !== exp) begin
            $display("Fail %s port got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int k = 0; k < 6; k++) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    // match an output transfer against the lane queue heads
    task automatic take_output(input int p, input flit_t got);
        bit found;
        int k;
        found = 1'b0;
        // this port first and then any port to catch misrouting
        for (int l = 0; l < 2 && !found; l++) begin
            k = l * 3 + p;
            if (exp_q[k].size() > 0 && exp_q[k][0] == got) begin
                found = 1'b1;
                void'(exp_q[k].pop_front());
            end
        end
        for (k = 0; k < 6 && !found; k++) begin
            if (exp_q[k].size() > 0 && exp_q[k][0] == got) begin
                found = 1'b1;
                check_port(port_label(p), port_sel_t'(p), port_sel_t'(k % 3));
                void'(exp_q[k].pop_front());
            end
        end
        if (!found && exp_q[p].size() > 0) begin
            check_flit(port_label(p), got, exp_q[p][0]);
        end else if (!found && exp_q[3 + p].size() > 0) begin
            check_flit(port_label(p), got, exp_q[3 + p][0]);
        end else if (!found) begin
            $display("unexpected flit %h left on %s with nothing pending", got, port_label(p));
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // drivers and monitor
    ////////////////////////////////////////

    // one lane's share of a test with each flit held until accepted
    task automatic send_lane(input int lane, input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (v_lane[i] == lane) begin
                if (v_gap[i] > 0) begin
                    in_valid[lane] <= 1'b0;
                    repeat (v_gap[i]) @(posedge clk);
                end
                in_data[lane]  <= v_flit[i];
                in_valid[lane] <= 1'b1;
                exp_q[lane * 3 + v_port[i]].push_back(v_flit[i]);
                do @(posedge clk); while (!in_ready[lane]);
            end
        end
        in_valid[lane] <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles with %0d flits undelivered", cycles, pending());
            $display("Simulation failed");
            $finish;
        end
    end

    // long stall at the start of a back-pressure test then random readys
    initial begin
        void'($urandom(32'h03eb_a202));
        forever begin
            @(posedge clk);
            if (!bp_mode) begin
                o_ready <= 3'b111;
            end else if (cycles - test_start < 12) begin
                o_ready <= 3'b000;
            end else begin
                o_ready <= 3'($urandom);
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            for (int p = 0; p < 3; p++) begin
                // stalled stage must hold its flit
                if (held[p]) begin
                    check_bit({port_label(p), "_valid"}, o_valid[p], 1'b1);
                    check_flit(port_label(p), o_data[p], held_data[p]);
                end
                if (o_valid[p] && o_ready[p]) begin
                    take_output(p, o_data[p]);
                end
                held[p]      = o_valid[p] && !o_ready[p];
                held_data[p] = o_data[p];
            end
            for (int l = 0; l < 2; l++) begin
                if (bp_mode && in_valid[l] && !in_ready[l]) begin
                    stall_cnt++;
                end
            end
        end
    end

    task automatic report_test(input int tid, input bit ok);
        $display("test %0d %s", tid, ok ? "ok" : "bad");
        if (ok) begin
            n_ok++;
        end else begin
            n_bad++;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int    fd;
        int    r;
        int    t;
        int    ln;
        int    dx;
        int    dy;
        int    g;
        int    p;
        int    bp;
        logic [`NOC_PAYLOAD_W-1:0] pl;
        string line;
        int    idx;
        int    first;
        int    tid;
        int    use_bp;
        int    err0;
        int    stall0;

        arst_n     = 1'b0;
        in_data[0] = '0;
        in_data[1] = '0;
        in_valid   = '0;
        o_ready    = 3'b111;
        bp_mode    = 1'b0;
        held       = '0;
        errors     = 0;
        cycles     = 0;
        limit      = 200;
        test_start = 0;
        stall_cnt  = 0;
        n_vec      = 0;
        n_ok       = 0;
        n_bad      = 0;

        fd = $fopen("mesh_router_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            $display("Simulation failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r > 1 && line.getc(0) != "#") begin
                    r = $sscanf(line, "%d %d %d %d %h %d %d %d", t, ln, dx, dy, pl, g, p, bp);
                    if (r == 8 && n_vec < MAX_VEC) begin
                        v_test[n_vec]         = t;
                        v_lane[n_vec]         = ln;
                        v_flit[n_vec].dst_x   = coord_t'(dx);
                        v_flit[n_vec].dst_y   = coord_t'(dy);
                        v_flit[n_vec].payload = pl;
                        v_gap[n_vec]          = g;
                        v_port[n_vec]         = p;
                        v_bp[n_vec]           = bp;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
            limit = 60 * n_vec + 200;
            if (n_vec == 0) begin
                $display("no vectors found in the vector file");
                errors++;
            end

            repeat (8) @(posedge clk);
            arst_n <= 1'b1;
            @(posedge clk);

            // idle state right after reset
            err0 = errors;
            for (int k = 0; k < 3; k++) begin
                check_bit({port_label(k), "_valid"}, o_valid[k], 1'b0);
            end
            check_bit("in_xpos_ready", in_ready[0], 1'b1);
            check_bit("in_ypos_ready", in_ready[1], 1'b1);
            report_test(0, errors == err0);

            idx = 0;
            while (idx < n_vec) begin
                first  = idx;
                tid    = v_test[idx];
                use_bp = 0;
                while (idx < n_vec && v_test[idx] == tid) begin
                    use_bp = use_bp | v_bp[idx];
                    idx++;
                end
                err0       = errors;
                stall0     = stall_cnt;
                test_start = cycles;
                bp_mode   <= (use_bp != 0);
                fork
                    send_lane(0, first, idx - 1);
                    send_lane(1, first, idx - 1);
                join
                while (pending() != 0) begin
                    @(posedge clk);
                end
                if (use_bp != 0 && stall_cnt == stall0) begin
                    $display("test %0d never stalled an input under back-pressure", tid);
                    errors++;
                end
                bp_mode <= 1'b0;
                repeat (4) @(posedge clk);
                report_test(tid, errors == err0);
            end

            $display("tests finished with %0d ok and %0d bad", n_ok, n_bad);
            if (errors == 0 && n_bad == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule
